/* project.f */
+incdir+dv
source/mem_cfg_pkg.sv
source/axil_pkg.sv
source/sram.sv
source/sram_banked.sv
source/read_resp_buf.sv
source/axil_sram_ctrl.sv
source/axil_sram_top.sv
dv/tb_axil_sram.sv

/* dv/tb_axil_sram_tasks.svh */
// ==========================================================
// LFSR and AXI4-Lite driver tasks; inputs change 1 ns after
// the rising edge, handshakes are sampled on the falling edge
// ==========================================================
`ifndef TB_AXIL_SRAM_TASKS_SVH
`define TB_AXIL_SRAM_TASKS_SVH

// fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
function automatic logic [31:0] lfsr_bits(input int unsigned n);
  logic [31:0] val;
  logic        fb;
  val = '0;
  for (int unsigned i = 0; i < n; i++) begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    val    = {val[30:0], fb};
  end
  return val;
endfunction

// stall is the number of cycles bready stays low once bvalid is up
task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input int unsigned stall);
  s_awaddr_i  = addr;
  s_wdata_i   = data;
  s_wstrb_i   = strb;
  s_awvalid_i = 1'b1;
  s_wvalid_i  = 1'b1;
  do @(negedge clk_i); while (!s_awready_o);
  @(posedge clk_i);
  #1;
  s_awvalid_i = 1'b0;
  s_wvalid_i  = 1'b0;
  repeat (stall) begin
    @(posedge clk_i);
    #1;
  end
  s_bready_i = 1'b1;
  do @(negedge clk_i); while (!s_bvalid_o);
  @(posedge clk_i);
  #1;
  s_bready_i = 1'b0;
endtask

task automatic read_txn(input logic [31:0] addr, input int unsigned stall);
  s_araddr_i  = addr;
  s_arvalid_i = 1'b1;
  do @(negedge clk_i); while (!s_arready_o);
  @(posedge clk_i);
  #1;
  s_arvalid_i = 1'b0;
  repeat (stall) begin
    @(posedge clk_i);
    #1;
  end
  s_rready_i = 1'b1;
  do @(negedge clk_i); while (!s_rvalid_o);
  @(posedge clk_i);
  #1;
  s_rready_i = 1'b0;
endtask

`endif

/* dv/tb_axil_sram.sv */
// ==========================================================
// testbench for the AXI4-Lite scratchpad with one master
// that always offers AW and W together; checks run on the
// falling edge where all DUT outputs have settled
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tb_axil_sram;

  // 40 cycles for each of the 107 transactions below
  localparam int unsigned MAX_CYCLES = 40 * 107;
  localparam int unsigned CUT_BYTES  = mem_cfg_pkg::CUT_WORDS * mem_cfg_pkg::STRB_WIDTH;

  logic        clk_i;
  logic        rst_ni = 1'b0;
  logic        s_awvalid_i = 1'b0, s_wvalid_i = 1'b0, s_bready_i = 1'b0;
  logic        s_arvalid_i = 1'b0, s_rready_i = 1'b0;
  logic [31:0] s_awaddr_i = '0, s_wdata_i = '0, s_araddr_i = '0;
  logic [3:0]  s_wstrb_i = '0;
  logic        s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
  logic [31:0] s_rdata_o;
  logic [1:0]  s_bresp_o, s_rresp_o;

  logic [31:0] lfsr_q = 32'h371d_c4ff;
  logic [31:0] waddr, wdata, exp_rdata, rdata_d;
  logic [1:0]  exp_bresp, exp_rresp, bresp_d, rresp_d;
  logic        hs_w, hs_r, hs_b, hs_rd, w_d1, r_d1, r_d2, busy, rst_d;
  logic        bvalid_d, bready_d, rvalid_d, rready_d;
  logic [7:0]  ref_mem [mem_cfg_pkg::N_WORDS][mem_cfg_pkg::STRB_WIDTH];
  logic [31:0] touched [$];
  int unsigned err_cnt, err_mark, tests_run, tests_failed, cycle_cnt, widx;

  // each of these completes on the next rising edge
  assign hs_w  = s_awvalid_i && s_awready_o && s_wvalid_i && s_wready_o;
  assign hs_r  = s_arvalid_i && s_arready_o;
  assign hs_b  = s_bvalid_o && s_bready_i;
  assign hs_rd = s_rvalid_o && s_rready_i;

  axil_sram_top u_dut (.*);

  `include "tb_axil_sram_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= MAX_CYCLES);
    $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic flag_error(input string msg);
    err_cnt++;
    $display("Fail at %0d ns: %s", $time, msg);
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (err_cnt != err_mark) begin
      tests_failed++;
      $display("Fail at %0d ns: %s, %0d check(s) failed", $time, name, err_cnt - err_mark);
    end else begin
      $display("%0d ns: %s ok", $time, name);
    end
    err_mark = err_cnt;
  endtask

  // raises AW and W right after the AR handshake so they queue behind the read
  task automatic offer_write_after_ar(input logic [31:0] addr, input logic [31:0] data);
    do @(negedge clk_i); while (!hs_r);
    @(posedge clk_i);
    #1;
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_wstrb_i   = 4'hf;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
  endtask

  always @(negedge clk_i) begin
    if (!rst_ni || !rst_d) begin
      assert (!(s_awready_o || s_wready_o || s_arready_o || s_bvalid_o || s_rvalid_o))
        else flag_error("ready or valid high during or right after reset");
    end else begin
      assert (s_awready_o == s_wready_o) else flag_error("awready and wready differ");
      assert ((s_bvalid_o && !bvalid_d) == w_d1)
        else flag_error("bvalid not exactly one cycle after the write handshake");
      assert ((s_rvalid_o && !rvalid_d) == r_d2)
        else flag_error("rvalid not exactly two cycles after the AR handshake");
      assert (!(bvalid_d && !bready_d) || (s_bvalid_o && s_bresp_o == bresp_d))
        else flag_error("B channel changed under back-pressure");
      assert (!(rvalid_d && !rready_d) || (s_rvalid_o && s_rresp_o == rresp_d
              && s_rdata_o === rdata_d))
        else flag_error("R channel changed under back-pressure");
      assert (!(busy && (hs_w || hs_r)))
        else flag_error("address accepted while a response was pending");
      assert (!(hs_r && (s_awvalid_i || s_wvalid_i)))
        else flag_error("read accepted ahead of a pending write");
      assert (!hs_b || s_bresp_o == exp_bresp)
        else flag_error($sformatf("bresp %0d, expected %0d", s_bresp_o, exp_bresp));
      assert (!hs_rd || (s_rresp_o == exp_rresp && s_rdata_o === exp_rdata))
        else flag_error($sformatf("read returned %h/%0d, expected %h/%0d",
                                  s_rdata_o, s_rresp_o, exp_rdata, exp_rresp));
    end
    // the reference model indexes words by address bits 13:2
    if (hs_w) begin
      exp_bresp = (s_awaddr_i < mem_cfg_pkg::MEM_BYTES) ? axil_pkg::RESP_OKAY
                                                         : axil_pkg::RESP_SLVERR;
      widx = (s_awaddr_i >> 2) % mem_cfg_pkg::N_WORDS;
      for (int b = 0; b < mem_cfg_pkg::STRB_WIDTH; b++) begin
        if (s_wstrb_i[b] && exp_bresp == axil_pkg::RESP_OKAY) begin
          ref_mem[widx][b] = s_wdata_i[8*b +: 8];
        end
      end
    end
    if (hs_r) begin
      exp_rresp = (s_araddr_i < mem_cfg_pkg::MEM_BYTES) ? axil_pkg::RESP_OKAY
                                                         : axil_pkg::RESP_SLVERR;
      widx = (s_araddr_i >> 2) % mem_cfg_pkg::N_WORDS;
      for (int b = 0; b < mem_cfg_pkg::STRB_WIDTH; b++) begin
        exp_rdata[8*b +: 8] = (exp_rresp == axil_pkg::RESP_OKAY) ? ref_mem[widx][b] : 8'h00;
      end
    end
    busy     = rst_ni && (hs_w || hs_r || (busy && !hs_b && !hs_rd));
    w_d1     = hs_w;
    r_d2     = r_d1;
    r_d1     = hs_r;
    bvalid_d = s_bvalid_o;
    bready_d = s_bready_i;
    bresp_d  = s_bresp_o;
    rvalid_d = s_rvalid_o;
    rready_d = s_rready_i;
    rresp_d  = s_rresp_o;
    rdata_d  = s_rdata_o;
    rst_d    = rst_ni;
  end

  initial begin
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    close_test("reset state");
    for (int i = 0; i < 8; i++) begin
      waddr = lfsr_bits(14);
      touched.push_back(waddr);
      write_txn(waddr, lfsr_bits(32), 4'hf, 0);
      read_txn(waddr, 0);
    end
    close_test("full-word write and read-back");
    for (int i = 0; i < 4; i++) begin
      waddr = lfsr_bits(14);
      touched.push_back(waddr);
      write_txn(waddr, lfsr_bits(32), 4'hf, 0);
      for (int j = 0; j < 3; j++) begin
        write_txn(waddr, lfsr_bits(32), lfsr_bits(4), 0);
        read_txn(waddr, 0);
      end
    end
    close_test("byte strobes");
    // the same offset is used in every cut and the low data bits carry the cut number
    for (int k = 0; k < 2; k++) begin
      waddr = lfsr_bits(10) << 2;
      for (int c = 0; c < 4; c++) begin
        touched.push_back(waddr + c * CUT_BYTES);
        write_txn(waddr + c * CUT_BYTES, (lfsr_bits(30) << 2) | 32'(c), 4'hf, 0);
      end
      for (int c = 0; c < 4; c++) begin
        read_txn(waddr + ((c * 3) % 4) * CUT_BYTES, 0);
      end
    end
    close_test("cut decoding");
    // these alias touched words in bits 13:2 and must leave them alone
    for (int i = 0; i < 4; i++) begin
      write_txn(touched[i] + mem_cfg_pkg::MEM_BYTES, lfsr_bits(32), 4'hf, 0);
      read_txn(touched[i] + mem_cfg_pkg::MEM_BYTES, 0);
    end
    write_txn(32'hffff_fffc, lfsr_bits(32), 4'hf, 0);
    read_txn(32'hffff_fffc, 0);
    foreach (touched[i]) begin
      read_txn(touched[i], 0);
    end
    close_test("out-of-range accesses");
    for (int i = 0; i < 8; i++) begin
      waddr = lfsr_bits(14);
      wdata = lfsr_bits(32);
      // the last two offer AR in the same cycle as AW and W
      if (i >= 6) begin
        s_araddr_i  = waddr;
        s_arvalid_i = 1'b1;
      end
      write_txn(waddr, wdata, 4'hf, lfsr_bits(3));
      if (i == 4) begin
        // the same write waits behind this read until its response is taken
        fork
          read_txn(waddr, 4);
          offer_write_after_ar(waddr, wdata);
        join
        write_txn(waddr, wdata, 4'hf, 0);
      end else begin
        read_txn(waddr, lfsr_bits(3));
      end
    end
    close_test("back-pressure and priority");
    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/axil_sram_top.sv */
// ==========================================================
// 16 KiB AXI4-Lite scratchpad; no bursts, no outstanding
// transactions, AWPROT/ARPROT are not present
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module axil_sram_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                s_awvalid_i,
  output logic                                s_awready_o,
  input  logic [mem_cfg_pkg::ADDR_WIDTH-1:0]  s_awaddr_i,
  input  logic                                s_wvalid_i,
  output logic                                s_wready_o,
  input  logic [mem_cfg_pkg::DATA_WIDTH-1:0]  s_wdata_i,
  input  logic [mem_cfg_pkg::STRB_WIDTH-1:0]  s_wstrb_i,
  output logic                                s_bvalid_o,
  input  logic                                s_bready_i,
  output logic [1:0]                          s_bresp_o,
  input  logic                                s_arvalid_i,
  output logic                                s_arready_o,
  input  logic [mem_cfg_pkg::ADDR_WIDTH-1:0]  s_araddr_i,
  output logic                                s_rvalid_o,
  input  logic                                s_rready_i,
  output logic [mem_cfg_pkg::DATA_WIDTH-1:0]  s_rdata_o,
  output logic [1:0]                          s_rresp_o
);

  logic                               mem_req;
  logic                               mem_we;
  logic [mem_cfg_pkg::WORD_AW-1:0]    mem_addr;
  logic [mem_cfg_pkg::DATA_WIDTH-1:0] mem_wdata;
  logic [mem_cfg_pkg::STRB_WIDTH-1:0] mem_be;
  logic [mem_cfg_pkg::DATA_WIDTH-1:0] mem_rdata;
  logic [mem_cfg_pkg::DATA_WIDTH-1:0] rd_data;
  logic                               rd_capture;
  logic                               rd_zero;
  logic                               rd_done;
  axil_pkg::resp_e                    rd_resp;

  axil_sram_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .awvalid_i    (s_awvalid_i),
    .awready_o    (s_awready_o),
    .awaddr_i     (s_awaddr_i),
    .wvalid_i     (s_wvalid_i),
    .wready_o     (s_wready_o),
    .wdata_i      (s_wdata_i),
    .wstrb_i      (s_wstrb_i),
    .bvalid_o     (s_bvalid_o),
    .bready_i     (s_bready_i),
    .bresp_o      (s_bresp_o),
    .arvalid_i    (s_arvalid_i),
    .arready_o    (s_arready_o),
    .araddr_i     (s_araddr_i),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_be_o     (mem_be),
    .rd_capture_o (rd_capture),
    .rd_resp_o    (rd_resp),
    .rd_zero_o    (rd_zero),
    .rd_done_i    (rd_done)
  );

  sram_banked u_mem (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .be_i    (mem_be),
    .rdata_o (mem_rdata)
  );

  // an out-of-range read never reached the memory, so return zeros
  assign rd_data = rd_zero ? '0 : mem_rdata;

  read_resp_buf u_rbuf (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .capture_i (rd_capture),
    .data_i    (rd_data),
    .resp_i    (rd_resp),
    .rvalid_o  (s_rvalid_o),
    .rready_i  (s_rready_i),
    .rdata_o   (s_rdata_o),
    .rresp_o   (s_rresp_o),
    .done_o    (rd_done)
  );

endmodule

`default_nettype wire

/* source/axil_sram_ctrl.sv */
// ==========================================================
// AXI4-Lite slave control, one transaction at a time;
// writes win over reads, AW and W must arrive together,
// the low two address bits are ignored
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module axil_sram_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // write address channel
  input  logic                                awvalid_i,
  output logic                                awready_o,
  input  logic [mem_cfg_pkg::ADDR_WIDTH-1:0]  awaddr_i,
  // write data channel
  input  logic                                wvalid_i,
  output logic                                wready_o,
  input  logic [mem_cfg_pkg::DATA_WIDTH-1:0]  wdata_i,
  input  logic [mem_cfg_pkg::STRB_WIDTH-1:0]  wstrb_i,
  // write response channel
  output logic                                bvalid_o,
  input  logic                                bready_i,
  output axil_pkg::resp_e                     bresp_o,
  // read address channel
  input  logic                                arvalid_i,
  output logic                                arready_o,
  input  logic [mem_cfg_pkg::ADDR_WIDTH-1:0]  araddr_i,
  // memory request
  output logic                                mem_req_o,
  output logic                                mem_we_o,
  output logic [mem_cfg_pkg::WORD_AW-1:0]     mem_addr_o,
  output logic [mem_cfg_pkg::DATA_WIDTH-1:0]  mem_wdata_o,
  output logic [mem_cfg_pkg::STRB_WIDTH-1:0]  mem_be_o,
  // read response buffer
  output logic                                rd_capture_o,
  output axil_pkg::resp_e                     rd_resp_o,
  output logic                                rd_zero_o,
  input  logic                                rd_done_i
);

  axil_pkg::ctrl_state_e state_q, state_d;
  axil_pkg::resp_e       bresp_q;
  logic                  rd_oor_q;

  logic idle;
  logic write_go;
  logic read_go;
  logic aw_in_range;
  logic ar_in_range;

  assign idle = (state_q == axil_pkg::ST_IDLE);

  // a write needs both AW and W; a pending write blocks the read
  assign write_go = idle && awvalid_i && wvalid_i;
  assign read_go  = idle && arvalid_i && !awvalid_i && !wvalid_i;

  assign aw_in_range = (awaddr_i < mem_cfg_pkg::MEM_BYTES);
  assign ar_in_range = (araddr_i < mem_cfg_pkg::MEM_BYTES);

  always_comb begin
    state_d = state_q;
    case (state_q)
      axil_pkg::ST_IDLE: begin
        if (write_go) begin
          state_d = axil_pkg::ST_WRESP;
        end else if (read_go) begin
          state_d = axil_pkg::ST_RWAIT;
        end
      end
      axil_pkg::ST_WRESP: begin
        if (bready_i) begin
          state_d = axil_pkg::ST_IDLE;
        end
      end
      // memory data is on its way, hand it to the buffer this cycle
      axil_pkg::ST_RWAIT: begin
        state_d = axil_pkg::ST_RRESP;
      end
      axil_pkg::ST_RRESP: begin
        if (rd_done_i) begin
          state_d = axil_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = axil_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= axil_pkg::ST_IDLE;
      bresp_q  <= axil_pkg::RESP_OKAY;
      rd_oor_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (write_go) begin
        bresp_q <= aw_in_range ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
      end
      if (read_go) begin
        rd_oor_q <= !ar_in_range;
      end
    end
  end

  // channel handshakes
  assign awready_o = write_go;
  assign wready_o  = write_go;
  assign arready_o = read_go;
  assign bvalid_o  = (state_q == axil_pkg::ST_WRESP);
  assign bresp_o   = bresp_q;

  // the memory is accessed on the handshake edge itself, only when in range
  assign mem_req_o   = (write_go && aw_in_range) || (read_go && ar_in_range);
  assign mem_we_o    = write_go;
  assign mem_addr_o  = write_go ? awaddr_i[mem_cfg_pkg::WORD_AW+1:2]
                                : araddr_i[mem_cfg_pkg::WORD_AW+1:2];
  assign mem_wdata_o = wdata_i;
  assign mem_be_o    = wstrb_i;

  // read response handoff
  assign rd_capture_o = (state_q == axil_pkg::ST_RWAIT);
  assign rd_resp_o    = rd_oor_q ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
  assign rd_zero_o    = rd_oor_q;

endmodule

`default_nettype wire

/* source/read_resp_buf.sv */
// ==========================================================
// R channel holding register; data and response stay put
// while rvalid_o is high and rready_i is low
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module read_resp_buf (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                capture_i,
  input  logic [mem_cfg_pkg::DATA_WIDTH-1:0]  data_i,
  input  axil_pkg::resp_e                     resp_i,
  output logic                                rvalid_o,
  input  logic                                rready_i,
  output logic [mem_cfg_pkg::DATA_WIDTH-1:0]  rdata_o,
  output axil_pkg::resp_e                     rresp_o,
  output logic                                done_o
);

  logic                               rvalid_q;
  logic [mem_cfg_pkg::DATA_WIDTH-1:0] data_q;
  axil_pkg::resp_e                    resp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (capture_i) begin
      rvalid_q <= 1'b1;
    end else if (done_o) begin
      rvalid_q <= 1'b0;
    end
  end

  // payload is only loaded on capture, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      data_q <= data_i;
      resp_q <= resp_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = data_q;
  assign rresp_o  = resp_q;

  // the handshake itself tells the controller the read is over
  assign done_o = rvalid_q && rready_i;

endmodule

`default_nettype wire

/* source/sram_banked.sv */
// ==========================================================
// four SRAM cuts behind one word address; the upper bits
// pick the cut, read data is valid one cycle after req_i
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module sram_banked (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [mem_cfg_pkg::WORD_AW-1:0]     addr_i,
  input  logic [mem_cfg_pkg::DATA_WIDTH-1:0]  wdata_i,
  input  logic [mem_cfg_pkg::STRB_WIDTH-1:0]  be_i,
  output logic [mem_cfg_pkg::DATA_WIDTH-1:0]  rdata_o
);

  logic [mem_cfg_pkg::CUT_SEL_W-1:0]  cut_sel;
  logic [mem_cfg_pkg::CUT_SEL_W-1:0]  sel_q;
  logic [mem_cfg_pkg::CUT_AW-1:0]     cut_addr;
  logic [mem_cfg_pkg::DATA_WIDTH-1:0] cut_rdata [mem_cfg_pkg::NB_CUTS];

  assign cut_sel  = addr_i[mem_cfg_pkg::WORD_AW-1:mem_cfg_pkg::CUT_AW];
  assign cut_addr = addr_i[mem_cfg_pkg::CUT_AW-1:0];

  // remember which cut answered so its output can be steered next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
    end else if (req_i) begin
      sel_q <= cut_sel;
    end
  end

  for (genvar i = 0; i < mem_cfg_pkg::NB_CUTS; i++) begin : gen_cut
    logic cut_req;

    // exactly one cut sees the request
    assign cut_req = req_i && (cut_sel == mem_cfg_pkg::CUT_SEL_W'(i));

    sram u_sram (
      .clk_i   (clk_i),
      .req_i   (cut_req),
      .we_i    (we_i),
      .addr_i  (cut_addr),
      .wdata_i (wdata_i),
      .be_i    (be_i),
      .rdata_o (cut_rdata[i])
    );
  end

  assign rdata_o = cut_rdata[sel_q];

endmodule

`default_nettype wire

/* source/sram.sv */
// ==========================================================
// behavioral single-port SRAM cut, one-cycle read latency;
// contents power up undefined and are never reset
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module sram (
  input  logic                                clk_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [mem_cfg_pkg::CUT_AW-1:0]      addr_i,
  input  logic [mem_cfg_pkg::DATA_WIDTH-1:0]  wdata_i,
  input  logic [mem_cfg_pkg::STRB_WIDTH-1:0]  be_i,
  output logic [mem_cfg_pkg::DATA_WIDTH-1:0]  rdata_o
);

  logic [mem_cfg_pkg::DATA_WIDTH-1:0] mem_q [mem_cfg_pkg::CUT_WORDS];

  // a write touches only the enabled lanes, a read loads the output register
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int unsigned i = 0; i < mem_cfg_pkg::STRB_WIDTH; i++) begin
          if (be_i[i]) begin
            mem_q[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* source/axil_pkg.sv */
// ==========================================================
// AXI4-Lite response codes and the controller FSM states;
// only OKAY and SLVERR are ever returned
// ==========================================================

`default_nettype none

package axil_pkg;

  // encodings follow the AXI BRESP/RRESP field
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // one transaction in flight at a time
  typedef enum logic [1:0] {
    ST_IDLE  = 2'b00,
    ST_WRESP = 2'b01,
    ST_RWAIT = 2'b10,
    ST_RRESP = 2'b11
  } ctrl_state_e;

endpackage

`default_nettype wire

/* source/mem_cfg_pkg.sv */
// ==========================================================
// geometry of the 16 KiB scratchpad, four 1024-word cuts
// of 32-bit words; byte addresses at or above MEM_BYTES
// are out of range and never reach the memory
// ==========================================================

`default_nettype none

package mem_cfg_pkg;

  // word and byte-lane widths
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  // cut organization
  localparam int unsigned CUT_WORDS  = 1024;
  localparam int unsigned NB_CUTS    = 4;
  localparam int unsigned N_WORDS    = CUT_WORDS * NB_CUTS;
  localparam int unsigned CUT_AW     = $clog2(CUT_WORDS);
  localparam int unsigned CUT_SEL_W  = $clog2(NB_CUTS);
  localparam int unsigned WORD_AW    = CUT_AW + CUT_SEL_W;

  // bus side
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned MEM_BYTES  = N_WORDS * STRB_WIDTH;

endpackage

`default_nettype wire
